// File: logic/rename_pkg.sv
`default_nettype none

package rename_pkg;

    // Register file sizes
    localparam int ARCH_REGS = 32;
    localparam int PHYS_REGS = 64;

    // Tags not held by the committed map at any time
    localparam int FREE_DEPTH = PHYS_REGS - ARCH_REGS;

    localparam int AREG_W = $clog2(ARCH_REGS);  // Architectural index
    localparam int TAG_W = $clog2(PHYS_REGS);   // Physical tag

    typedef logic [AREG_W-1:0] arch_reg_t;
    typedef logic [TAG_W-1:0] phys_tag_t;

endpackage

`default_nettype wire

// File: logic/free_list.sv
`timescale 1ns/10ps
`default_nettype none

module free_list (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         alloc,          // Pop at the tail
    input  logic                         release_valid,  // Push at the head
    input  rename_pkg::phys_tag_t        release_tag,
    input  logic                         flush,
    output rename_pkg::phys_tag_t        free_tag,
    output logic                         empty,
    output logic [rename_pkg::TAG_W-1:0] count
);

    // Queue index, and pointer with one wrap bit above it
    typedef logic [$clog2(rename_pkg::FREE_DEPTH)-1:0] idx_t;
    typedef logic [$clog2(rename_pkg::FREE_DEPTH):0] ptr_t;

    rename_pkg::phys_tag_t entries [rename_pkg::FREE_DEPTH];

    ptr_t head;         // Next slot to fill on release
    ptr_t tail;         // Next tag to hand out
    ptr_t commit_tail;  // Tail as seen by committed instructions
    ptr_t head_next;
    ptr_t tail_next;
    ptr_t commit_tail_next;

    idx_t head_idx;
    idx_t tail_idx;
    logic full;

    assign head_idx = idx_t'(head);
    assign tail_idx = idx_t'(tail);

    // Same index with different wrap bits means every slot holds a tag
    assign empty = (head == tail);
    assign full = (head_idx == tail_idx) && (head[$high(head)] != tail[$high(tail)]);
    assign count = head - tail;

    assign free_tag = entries[tail_idx];  // Oldest free tag

    always_comb begin
        head_next = head;
        commit_tail_next = commit_tail;
        tail_next = tail;

        if (release_valid) begin
            head_next = head + 1'b1;
            // Every commit retires one earlier allocation
            commit_tail_next = commit_tail + 1'b1;
        end

        if (flush) begin
            tail_next = commit_tail_next;  // Drop uncommitted allocations
        end else if (alloc) begin
            tail_next = tail + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            head <= ptr_t'(rename_pkg::FREE_DEPTH);  // Starts full
            tail <= '0;
            commit_tail <= '0;
        end else begin
            head <= head_next;
            tail <= tail_next;
            commit_tail <= commit_tail_next;
        end
    end

    // Out of reset the queue holds the tags above the architectural range
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < rename_pkg::FREE_DEPTH; i++) begin
                entries[i] <= rename_pkg::phys_tag_t'(rename_pkg::ARCH_REGS + i);
            end
        end else if (release_valid) begin
            entries[head_idx] <= release_tag;
        end
    end

    // The top stalls rename before the queue runs dry
    no_alloc_when_empty: assert property (
        @(posedge clk) disable iff (rst) alloc |-> !empty
    );

    // A released tag always has a slot, since the committed map holds the rest
    no_release_when_full: assert property (
        @(posedge clk) disable iff (rst) release_valid |-> !full
    );

endmodule

`default_nettype wire

// File: logic/spec_map.sv
`timescale 1ns/10ps
`default_nettype none

module spec_map (
    input  logic                  clk,
    input  logic                  rst,
    input  rename_pkg::arch_reg_t rs1,
    input  rename_pkg::arch_reg_t rs2,
    input  rename_pkg::arch_reg_t rd,
    input  logic                  write,
    input  rename_pkg::phys_tag_t new_tag,
    input  logic                  flush,
    input  rename_pkg::phys_tag_t restore_map [rename_pkg::ARCH_REGS],
    output rename_pkg::phys_tag_t rs1_tag,
    output rename_pkg::phys_tag_t rs2_tag,
    output rename_pkg::phys_tag_t old_tag
);

    // Newest tag of each architectural register
    rename_pkg::phys_tag_t map [rename_pkg::ARCH_REGS];

    // Reads see the table before this cycle's write
    assign rs1_tag = map[rs1];
    assign rs2_tag = map[rs2];
    assign old_tag = map[rd];  // Tag that rd loses on rename

    always_ff @(posedge clk) begin
        if (rst) begin
            // Identity mapping
            for (int i = 0; i < rename_pkg::ARCH_REGS; i++) begin
                map[i] <= rename_pkg::phys_tag_t'(i);
            end
        end else if (flush) begin
            map <= restore_map;  // Back to the committed state
        end else if (write) begin
            map[rd] <= new_tag;
        end
    end

    // x0 keeps tag 0, so its entry is never renamed
    no_write_x0: assert property (
        @(posedge clk) disable iff (rst) write |-> (rd != '0)
    );

endmodule

`default_nettype wire

// File: logic/commit_map.sv
`timescale 1ns/10ps
`default_nettype none

module commit_map (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  commit_valid,
    input  rename_pkg::arch_reg_t commit_rd,
    input  rename_pkg::phys_tag_t commit_tag,
    output rename_pkg::phys_tag_t released_tag,
    output rename_pkg::phys_tag_t restore_map [rename_pkg::ARCH_REGS]
);

    rename_pkg::phys_tag_t map [rename_pkg::ARCH_REGS];
    rename_pkg::phys_tag_t map_next [rename_pkg::ARCH_REGS];

    always_comb begin
        map_next = map;
        if (commit_valid) begin
            map_next[commit_rd] = commit_tag;
        end
    end

    assign released_tag = map[commit_rd];  // Previous owner goes back to the free list

    // Flush in the commit cycle restores the post-commit mapping
    assign restore_map = map_next;

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < rename_pkg::ARCH_REGS; i++) begin
                map[i] <= rename_pkg::phys_tag_t'(i);
            end
        end else begin
            map <= map_next;
        end
    end

    // Instructions writing x0 allocate nothing and are never committed here
    no_commit_x0: assert property (
        @(posedge clk) disable iff (rst) commit_valid |-> (commit_rd != '0)
    );

    // A committing instruction must carry a freshly allocated tag
    commit_tag_is_new: assert property (
        @(posedge clk) disable iff (rst) commit_valid |-> (released_tag != commit_tag)
    );

endmodule

`default_nettype wire

// File: logic/rename_unit.sv
`timescale 1ns/10ps
`default_nettype none

module rename_unit (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         rename_valid,
    input  rename_pkg::arch_reg_t        rename_rd,
    input  rename_pkg::arch_reg_t        rename_rs1,
    input  rename_pkg::arch_reg_t        rename_rs2,
    input  logic                         commit_valid,
    input  rename_pkg::arch_reg_t        commit_rd,
    input  rename_pkg::phys_tag_t        commit_tag,
    input  logic                         flush,
    output rename_pkg::phys_tag_t        rs1_tag,
    output rename_pkg::phys_tag_t        rs2_tag,
    output rename_pkg::phys_tag_t        rd_tag,
    output rename_pkg::phys_tag_t        rd_old_tag,
    output logic                         rename_stall,
    output logic [rename_pkg::TAG_W-1:0] free_count
);

    logic                  rd_nonzero;
    logic                  accept;
    logic                  alloc;     // Pop the free list and write the map
    logic                  fl_empty;
    rename_pkg::phys_tag_t free_tag;
    rename_pkg::phys_tag_t old_tag;
    rename_pkg::phys_tag_t released_tag;
    rename_pkg::phys_tag_t restore_map [rename_pkg::ARCH_REGS];

    assign rd_nonzero = (rename_rd != '0);

    // Only an instruction that needs a tag waits for one
    assign rename_stall = rename_valid && rd_nonzero && fl_empty;
    assign accept = rename_valid && !flush && !rename_stall;
    assign alloc = accept && rd_nonzero;

    // x0 never renamed
    assign rd_tag = rd_nonzero ? free_tag : '0;
    assign rd_old_tag = rd_nonzero ? old_tag : '0;

    free_list u_free_list (
        .clk           (clk),
        .rst           (rst),
        .alloc         (alloc),
        .release_valid (commit_valid),
        .release_tag   (released_tag),
        .flush         (flush),
        .free_tag      (free_tag),
        .empty         (fl_empty),
        .count         (free_count)
    );

    spec_map u_spec_map (
        .clk         (clk),
        .rst         (rst),
        .rs1         (rename_rs1),
        .rs2         (rename_rs2),
        .rd          (rename_rd),
        .write       (alloc),
        .new_tag     (free_tag),
        .flush       (flush),
        .restore_map (restore_map),
        .rs1_tag     (rs1_tag),
        .rs2_tag     (rs2_tag),
        .old_tag     (old_tag)
    );

    commit_map u_commit_map (
        .clk          (clk),
        .rst          (rst),
        .commit_valid (commit_valid),
        .commit_rd    (commit_rd),
        .commit_tag   (commit_tag),
        .released_tag (released_tag),
        .restore_map  (restore_map)
    );

endmodule

`default_nettype wire

// File: sim/rename_cases.svh
`ifndef RENAME_CASES_SVH
`define RENAME_CASES_SVH

// Stimulus columns are rename valid, rd, rs1, rs2, commit valid, commit rd, commit tag, flush
// Then the expected rs1 tag, rs2 tag, rd tag, rd old tag, stall and free count before the edge
task automatic load_cases();
    // Reset state and first renames
    add_case(1, 5, 0, 0,  0, 0,  0,  0,   0,  0, 32,  5, 0, 32);  // rd 5 takes tag 32
    add_case(1, 6, 5, 0,  0, 0,  0,  0,  32,  0, 33,  6, 0, 31);  // rs1 5 sees tag 32
    add_case(1, 5, 6, 5,  0, 0,  0,  0,  33, 32, 34, 32, 0, 30);  // Second rename of rd 5

    // x0 is never renamed
    add_case(1, 0, 0, 5,  0, 0,  0,  0,   0, 34,  0,  0, 0, 29);
    add_case(0, 0, 0, 0,  0, 0,  0,  0,   0,  0,  0,  0, 0, 29);  // Count unchanged

    // Commit of rd 5 releases tag 5
    add_case(0, 0, 0, 0,  1, 5, 32,  0,   0,  0,  0,  0, 0, 29);
    add_case(1, 7, 5, 6,  1, 6, 33,  0,  34, 33, 35,  7, 0, 30);  // Rename and commit together

    // Uncommitted rename, then flush back to the committed map
    add_case(1, 8, 7, 5,  0, 0,  0,  0,  35, 34, 36,  8, 0, 30);
    add_case(1, 9, 0, 0,  0, 0,  0,  1,   0,  0, 37,  9, 0, 29);  // Flush blocks the rename
    add_case(1, 7, 5, 8,  0, 0,  0,  0,  32,  8, 34,  7, 0, 32);  // Tag 34 handed out again
    add_case(1, 9, 7, 6,  0, 0,  0,  0,  34, 33, 35,  9, 0, 31);

    // Flush in the same cycle as the commit of rd 7
    add_case(0, 0, 0, 0,  1, 7, 34,  1,   0,  0,  0,  0, 0, 30);
    add_case(1, 9, 7, 9,  0, 0,  0,  0,  34,  9, 35,  9, 0, 32);  // Commit kept, rd 9 rolled back
    add_case(0, 0, 5, 7,  0, 0,  0,  0,  32, 34,  0,  0, 0, 31);

    // x0 rename alongside a commit
    add_case(1, 0, 9, 0,  1, 9, 35,  0,  35,  0,  0,  0, 0, 31);
    add_case(0, 0, 9, 7,  0, 0,  0,  0,  35, 34,  0,  0, 0, 32);
endtask

`endif

// File: sim/rename_tb.sv
`timescale 1ns/10ps
`default_nettype none

module rename_tb;

    localparam int STALL_TIMEOUT = 20;  // Cycles allowed for a stall to clear

    typedef struct packed {
        logic                         rename_valid;
        rename_pkg::arch_reg_t        rd;
        rename_pkg::arch_reg_t        rs1;
        rename_pkg::arch_reg_t        rs2;
        logic                         commit_valid;
        rename_pkg::arch_reg_t        commit_rd;
        rename_pkg::phys_tag_t        commit_tag;
        logic                         flush;
        rename_pkg::phys_tag_t        exp_rs1;
        rename_pkg::phys_tag_t        exp_rs2;
        rename_pkg::phys_tag_t        exp_rd;
        rename_pkg::phys_tag_t        exp_old;
        logic                         exp_stall;
        logic [rename_pkg::TAG_W-1:0] exp_count;
    } case_t;

    logic                         clk;
    logic                         rst;
    logic                         rename_valid;
    rename_pkg::arch_reg_t        rename_rd;
    rename_pkg::arch_reg_t        rename_rs1;
    rename_pkg::arch_reg_t        rename_rs2;
    logic                         commit_valid;
    rename_pkg::arch_reg_t        commit_rd;
    rename_pkg::phys_tag_t        commit_tag;
    logic                         flush;
    rename_pkg::phys_tag_t        rs1_tag;
    rename_pkg::phys_tag_t        rs2_tag;
    rename_pkg::phys_tag_t        rd_tag;
    rename_pkg::phys_tag_t        rd_old_tag;
    logic                         rename_stall;
    logic [rename_pkg::TAG_W-1:0] free_count;

    case_t cases[$];
    int    errors;
    int    tests;
    int    failed_tests;
    int    seed;

    rename_unit dut_i (
        .clk          (clk),
        .rst          (rst),
        .rename_valid (rename_valid),
        .rename_rd    (rename_rd),
        .rename_rs1   (rename_rs1),
        .rename_rs2   (rename_rs2),
        .commit_valid (commit_valid),
        .commit_rd    (commit_rd),
        .commit_tag   (commit_tag),
        .flush        (flush),
        .rs1_tag      (rs1_tag),
        .rs2_tag      (rs2_tag),
        .rd_tag       (rd_tag),
        .rd_old_tag   (rd_old_tag),
        .rename_stall (rename_stall),
        .free_count   (free_count)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #20 clk = ~clk;
        end
    end

    function automatic void add_case(input int rv, input int rd, input int rs1, input int rs2,
                                     input int cv, input int crd, input int ctag, input int fl,
                                     input int e_rs1, input int e_rs2, input int e_rd,
                                     input int e_old, input int e_stall, input int e_count);
        case_t c;
        c.rename_valid = (rv != 0);
        c.rd = rename_pkg::arch_reg_t'(rd);
        c.rs1 = rename_pkg::arch_reg_t'(rs1);
        c.rs2 = rename_pkg::arch_reg_t'(rs2);
        c.commit_valid = (cv != 0);
        c.commit_rd = rename_pkg::arch_reg_t'(crd);
        c.commit_tag = rename_pkg::phys_tag_t'(ctag);
        c.flush = (fl != 0);
        c.exp_rs1 = rename_pkg::phys_tag_t'(e_rs1);
        c.exp_rs2 = rename_pkg::phys_tag_t'(e_rs2);
        c.exp_rd = rename_pkg::phys_tag_t'(e_rd);
        c.exp_old = rename_pkg::phys_tag_t'(e_old);
        c.exp_stall = (e_stall != 0);
        c.exp_count = e_count[rename_pkg::TAG_W-1:0];
        cases.push_back(c);
    endfunction

    function automatic rename_pkg::arch_reg_t random_reg(input logic nonzero);
        rename_pkg::arch_reg_t r;
        r = rename_pkg::arch_reg_t'($random(seed));
        if (nonzero && r == '0) begin
            r = rename_pkg::arch_reg_t'(1);
        end
        return r;
    endfunction

    task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            errors++;
            $display("error at %0d ns: %s is %0d, expected %0d", $time, name, got, exp);
        end
    endtask

    // Called right after a rising edge
    task automatic drive_row(input case_t c);
        rename_valid <= c.rename_valid;
        rename_rd <= c.rd;
        rename_rs1 <= c.rs1;
        rename_rs2 <= c.rs2;
        commit_valid <= c.commit_valid;
        commit_rd <= c.commit_rd;
        commit_tag <= c.commit_tag;
        flush <= c.flush;
    endtask

    task automatic drive_idle();
        rename_valid <= 1'b0;
        rename_rd <= '0;
        rename_rs1 <= '0;
        rename_rs2 <= '0;
        commit_valid <= 1'b0;
        commit_rd <= '0;
        commit_tag <= '0;
        flush <= 1'b0;
    endtask

    task automatic apply_reset();
        rst <= 1'b1;
        drive_idle();
        repeat (8) @(posedge clk);
        rst <= 1'b0;
    endtask

    task automatic check_row(input int idx, input case_t c);
        int errors_before;
        errors_before = errors;
        compare($sformatf("row %0d rs1_tag", idx), 32'(rs1_tag), 32'(c.exp_rs1));
        compare($sformatf("row %0d rs2_tag", idx), 32'(rs2_tag), 32'(c.exp_rs2));
        compare($sformatf("row %0d rd_tag", idx), 32'(rd_tag), 32'(c.exp_rd));
        compare($sformatf("row %0d rd_old_tag", idx), 32'(rd_old_tag), 32'(c.exp_old));
        compare($sformatf("row %0d rename_stall", idx), 32'(rename_stall), 32'(c.exp_stall));
        compare($sformatf("row %0d free_count", idx), 32'(free_count), 32'(c.exp_count));
        tests++;
        if (errors == errors_before) begin
            $display("row %0d ok", idx);
        end else begin
            failed_tests++;
            $display("row %0d failed", idx);
        end
    endtask

    // Fill every free tag with random renames, then stall until one commit frees a tag
    task automatic run_drain();
        rename_pkg::phys_tag_t model [rename_pkg::ARCH_REGS];  // Expected speculative map
        rename_pkg::arch_reg_t rd;
        rename_pkg::arch_reg_t rs1;
        rename_pkg::arch_reg_t rs2;
        rename_pkg::arch_reg_t first_rd;
        int                    errors_before;
        int                    waits;
        errors_before = errors;
        first_rd = '0;
        for (int r = 0; r < rename_pkg::ARCH_REGS; r++) begin
            model[r] = rename_pkg::phys_tag_t'(r);
        end
        for (int i = 0; i < rename_pkg::FREE_DEPTH; i++) begin
            rd = random_reg(1'b1);
            rs1 = random_reg(1'b0);
            rs2 = random_reg(1'b0);
            if (i == 0) begin
                first_rd = rd;
            end
            @(posedge clk);
            rename_valid <= 1'b1;
            rename_rd <= rd;
            rename_rs1 <= rs1;
            rename_rs2 <= rs2;
            @(negedge clk);
            compare($sformatf("drain %0d rs1_tag", i), 32'(rs1_tag), 32'(model[rs1]));
            compare($sformatf("drain %0d rs2_tag", i), 32'(rs2_tag), 32'(model[rs2]));
            compare($sformatf("drain %0d rd_tag", i), 32'(rd_tag),
                    32'(rename_pkg::ARCH_REGS + i));  // Tags leave in reset order
            compare($sformatf("drain %0d rd_old_tag", i), 32'(rd_old_tag), 32'(model[rd]));
            compare($sformatf("drain %0d rename_stall", i), 32'(rename_stall), 32'(0));
            compare($sformatf("drain %0d free_count", i), 32'(free_count),
                    32'(rename_pkg::FREE_DEPTH - i));
            model[rd] = rename_pkg::phys_tag_t'(rename_pkg::ARCH_REGS + i);
        end

        // Free list is now empty
        rd = random_reg(1'b1);
        @(posedge clk);
        rename_rd <= rd;
        rename_rs1 <= first_rd;
        rename_rs2 <= '0;
        @(negedge clk);
        compare("empty rename_stall", 32'(rename_stall), 32'(1));
        compare("empty free_count", 32'(free_count), 32'(0));

        // Oldest instruction commits and gives back the reset tag of its rd
        @(posedge clk);
        commit_valid <= 1'b1;
        commit_rd <= first_rd;
        commit_tag <= rename_pkg::phys_tag_t'(rename_pkg::ARCH_REGS);
        @(negedge clk);
        compare("commit cycle rename_stall", 32'(rename_stall), 32'(1));
        @(posedge clk);
        commit_valid <= 1'b0;
        @(negedge clk);
        waits = 1;
        while (rename_stall && waits < STALL_TIMEOUT) begin
            @(negedge clk);
            waits++;
        end
        if (rename_stall) begin
            errors++;
            $display("rename stall did not clear within %0d cycles after the commit",
                     STALL_TIMEOUT);
        end else begin
            compare("stall cycles after commit", waits, 32'(1));
            compare("released rd_tag", 32'(rd_tag), 32'(first_rd));
            compare("released rd_old_tag", 32'(rd_old_tag), 32'(model[rd]));
            compare("released rs1_tag", 32'(rs1_tag), 32'(model[first_rd]));
            compare("released free_count", 32'(free_count), 32'(1));
        end
        @(posedge clk);
        drive_idle();
        @(negedge clk);
        compare("after drain free_count", 32'(free_count), 32'(0));
        tests++;
        if (errors == errors_before) begin
            $display("drain test ok");
        end else begin
            failed_tests++;
            $display("drain test failed");
        end
    endtask

    initial begin
        seed = 19542;
        errors = 0;
        tests = 0;
        failed_tests = 0;
        rst = 1'b1;
        rename_valid = 1'b0;
        rename_rd = '0;
        rename_rs1 = '0;
        rename_rs2 = '0;
        commit_valid = 1'b0;
        commit_rd = '0;
        commit_tag = '0;
        flush = 1'b0;
        load_cases();
        apply_reset();

        for (int i = 0; i < cases.size(); i++) begin
            @(posedge clk);
            drive_row(cases[i]);
            @(negedge clk);  // Outputs settled, state not yet updated
            check_row(i, cases[i]);
        end
        @(posedge clk);
        apply_reset();  // Drain starts from the reset free list
        run_drain();

        $display("%0d tests, %0d failed, %0d mismatches", tests, failed_tests, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

`include "rename_cases.svh"

endmodule

`default_nettype wire

// File: flist.f
+incdir+sim
logic/rename_pkg.sv
logic/free_list.sv
logic/spec_map.sv
logic/commit_map.sv
logic/rename_unit.sv
sim/rename_tb.sv

// File: Makefile
# Verilator build and run of the register-rename testbench

.PHONY: all compile run clean

all: run

compile: obj_dir/rename_sim

obj_dir/rename_sim: flist.f logic/*.sv sim/*.sv sim/*.svh
	verilator --binary --timing --assert -j 0 -f flist.f --top-module rename_tb \
		-Mdir obj_dir -o rename_sim

# The log decides the result, a crash also counts as a failure
run: compile
	./obj_dir/rename_sim > sim.log 2>&1; status=$$?; cat sim.log; \
	if [ $$status -ne 0 ]; then \
		echo "simulation exited with status $$status"; exit 1; \
	fi
	@if grep -q "Done: errors found" sim.log; then \
		echo "Simulation failed, see sim.log"; \
		exit 1; \
	else \
		echo "Simulation passed"; \
	fi

clean:
	rm -rf obj_dir sim.log
